//--- alu_pkg.sv
// -------------------------------------------------------------------------
// integer execute unit package.
// holds the operation codes, the collector states and the default operand
// width shared by the execute unit and its testbench.
// -------------------------------------------------------------------------
package alu_pkg;

    // default operand width in bits.
    // the top level takes this as the default of its WORDSIZE parameter
    // and passes it down to every unit below it.
    parameter int WORDSIZE_DEFAULT = 64;

    // operation codes.
    // the requester places one of these on op together with both operands
    // and keeps it stable until ack rises.
    // the first five select the arithmetic unit output.
    // the last three turn a comparison flag into a 0/1 word.
    typedef enum logic [2:0] {
        op_add  = 3'd0,                     // a plus b modulo 2 to the word width.
        op_sub  = 3'd1,                     // a minus b modulo 2 to the word width.
        op_and  = 3'd2,                     // bitwise and of a and b.
        op_or   = 3'd3,                     // bitwise or of a and b.
        op_xor  = 3'd4,                     // bitwise exclusive or of a and b.
        op_slt  = 3'd5,                     // 1 when a is below b as signed values.
        op_sltu = 3'd6,                     // 1 when a is below b as unsigned values.
        op_seq  = 3'd7                      // 1 when a and b hold the same bits.
    } alu_op_t;

    // collector states of the four-phase handshake.
    // a request moves the machine from idle to ack in one cycle.
    // the machine stays in ack for as long as req stays high.
    // one release cycle follows before a new request can be taken.
    typedef enum logic [1:0] {
        st_idle    = 2'd0,                  // ack is low and req is watched.
        st_ack     = 2'd1,                  // outputs are registered and ack is high.
        st_release = 2'd2                   // ack has fallen and the machine rests a cycle.
    } exec_state_t;

endpackage

//--- flag_bus.sv
// -------------------------------------------------------------------------
// comparison flag bus.
// carries the seven ordering flags from the comparison unit to the
// result collector.
// -------------------------------------------------------------------------
interface flag_bus;

    logic equal;                            // operands hold the same bits.
    logic not_equal;                        // operands differ in at least one bit.
    logic greater;                          // a above b in two's complement order.
    logic less;                             // a below b in two's complement order.
    logic u_equal;                          // unsigned equality, same as equal.
    logic u_greater;                        // a above b in unsigned order.
    logic u_less;                           // a below b in unsigned order.

    // the comparison unit produces every flag.
    modport source (
        output equal,
        output not_equal,
        output greater,
        output less,
        output u_equal,
        output u_greater,
        output u_less
    );

    // the collector only samples the flags.
    modport sink (
        input equal,
        input not_equal,
        input greater,
        input less,
        input u_equal,
        input u_greater,
        input u_less
    );

endinterface

//--- compare_unit.sv
// -------------------------------------------------------------------------
// comparison unit.
// derives equality and the signed and unsigned ordering flags of two
// operands in one combinational step.
// -------------------------------------------------------------------------
module compare_unit #(
    parameter int WORDSIZE = alu_pkg::WORDSIZE_DEFAULT // operand width in bits.
) (
    input  logic [WORDSIZE-1:0] operand_a,  // first operand.
    input  logic [WORDSIZE-1:0] operand_b,  // second operand.
    flag_bus.source             flags       // ordering flags toward the collector.
);

    logic same_value;                       // both operands carry identical bits.
    logic u_above;                          // a is larger when read as unsigned.
    logic u_below;                          // a is smaller when read as unsigned.
    logic sign_a;                           // sign bit of the first operand.
    logic sign_b;                           // sign bit of the second operand.
    logic signs_differ;                     // exactly one operand is negative.

    assign same_value   = (operand_a == operand_b); // plain bitwise equality.
    assign u_above      = (operand_a > operand_b);  // both vectors are unsigned here.
    assign u_below      = (operand_a < operand_b);  // unsigned order again.

    assign sign_a       = operand_a[WORDSIZE-1]; // msb carries the two's complement sign.
    assign sign_b       = operand_b[WORDSIZE-1];
    assign signs_differ = sign_a ^ sign_b;      // mixed signs settle the order at once.

    // equality and unsigned order feed the bus directly.
    // the signed order only needs the sign bits on top of the unsigned order.
    always_comb begin
        flags.equal     = same_value;           // equal and not_equal are complements.
        flags.not_equal = ~same_value;
        flags.u_equal   = same_value;           // bit equality does not care about sign.
        flags.u_greater = u_above;
        flags.u_less    = u_below;

        if (signs_differ) begin
            // the negative operand is the smaller one.
            flags.greater = sign_b;             // b negative means a is above b.
            flags.less    = sign_a;             // a negative means a is below b.
        end else begin
            // with equal signs the unsigned order matches the signed order.
            // this holds for two negatives as well since both sit in the upper half.
            flags.greater = u_above;
            flags.less    = u_below;
        end
    end

endmodule

//--- arith_unit.sv
// -------------------------------------------------------------------------
// arithmetic and logic unit.
// add, subtract, and, or and xor on two operands with signed overflow
// detection on the shared adder.
// -------------------------------------------------------------------------
module arith_unit #(
    parameter int WORDSIZE = alu_pkg::WORDSIZE_DEFAULT // operand width in bits.
) (
    input  alu_pkg::alu_op_t    op,         // requested operation.
    input  logic [WORDSIZE-1:0] operand_a,  // first operand.
    input  logic [WORDSIZE-1:0] operand_b,  // second operand.
    output logic [WORDSIZE-1:0] sum,        // raw result before the collector picks.
    output logic                overflow    // signed overflow of add or subtract.
);

    logic                subtract;          // the adder works as a subtractor.
    logic [WORDSIZE-1:0] addend_b;          // second adder input after inversion.
    logic [WORDSIZE-1:0] carry_in;          // the subtract carry as a full word.
    logic [WORDSIZE-1:0] adder_out;         // output of the shared adder.
    logic                sign_a;            // sign of the first adder input.
    logic                sign_b;            // sign of the second adder input.
    logic                sign_out;          // sign of the adder output.
    logic                adder_overflow;    // signed overflow of the adder.
    logic                is_arith;          // op uses the adder result.

    // subtract is a plus the inverted b plus one.
    assign subtract  = (op == alu_pkg::op_sub);
    assign addend_b  = subtract ? ~operand_b : operand_b; // invert b only for subtract.
    assign carry_in  = {{(WORDSIZE-1){1'b0}}, subtract};  // the plus one of two's complement.
    assign adder_out = operand_a + addend_b + carry_in;   // carry out is dropped, modulo width.

    // two inputs of the same sign must give a result of that sign.
    // the check uses the inverted b so it also covers subtract.
    assign sign_a         = operand_a[WORDSIZE-1];
    assign sign_b         = addend_b[WORDSIZE-1];
    assign sign_out       = adder_out[WORDSIZE-1];
    assign adder_overflow = (sign_a == sign_b) && (sign_out != sign_a);

    assign is_arith = (op == alu_pkg::op_add) || (op == alu_pkg::op_sub);
    assign overflow = is_arith & adder_overflow; // logic operations never overflow.

    // result select.
    // the set operations leave the adder output here and the collector
    // replaces it with the 0/1 word of the matching flag.
    always_comb begin
        case (op)
            alu_pkg::op_and: sum = operand_a & operand_b; // bitwise and.
            alu_pkg::op_or:  sum = operand_a | operand_b; // bitwise or.
            alu_pkg::op_xor: sum = operand_a ^ operand_b; // bitwise xor.
            default:         sum = adder_out;             // add, subtract and the set ops.
        endcase
    end

endmodule

//--- exec_collect.sv
// -------------------------------------------------------------------------
// result collector.
// runs the four-phase handshake, picks the result for the operation and
// registers result, overflow and flags when a request is taken.
// -------------------------------------------------------------------------
module exec_collect #(
    parameter int WORDSIZE = alu_pkg::WORDSIZE_DEFAULT // operand width in bits.
) (
    input  logic                clk,            // rising edge clock.
    input  logic                rst,            // synchronous reset, active high.
    input  logic                req,            // four-phase request from the requester.
    input  alu_pkg::alu_op_t    op,             // operation held with the request.
    input  logic [WORDSIZE-1:0] sum,            // raw arithmetic unit result.
    input  logic                arith_overflow, // raw signed overflow.
    flag_bus.sink               flags,          // comparison unit flags.
    output logic                ack,            // four-phase acknowledge.
    output logic [WORDSIZE-1:0] result,         // registered result word.
    output logic                overflow,       // registered signed overflow.
    output logic                flag_equal,     // registered equality.
    output logic                flag_not_equal, // registered inequality.
    output logic                flag_greater,   // registered signed greater.
    output logic                flag_less,      // registered signed less.
    output logic                flag_u_equal,   // registered unsigned equality.
    output logic                flag_u_greater, // registered unsigned greater.
    output logic                flag_u_less     // registered unsigned less.
);

    alu_pkg::exec_state_t state;            // current handshake state.
    alu_pkg::exec_state_t state_next;       // state for the next edge.
    logic                 accept;           // req seen high while idle.
    logic                 req_dropped;      // req seen low while acknowledging.
    logic                 is_set_op;        // op returns a 0/1 word.
    logic                 set_bit;          // the flag chosen by a set op.
    logic [WORDSIZE-1:0]  result_next;      // value loaded into result on accept.

    // set operations map to one comparison flag each.
    always_comb begin
        is_set_op = 1'b1;
        case (op)
            alu_pkg::op_slt:  set_bit = flags.less;   // signed less.
            alu_pkg::op_sltu: set_bit = flags.u_less; // unsigned less.
            alu_pkg::op_seq:  set_bit = flags.equal;  // equality.
            default: begin
                is_set_op = 1'b0;               // arithmetic and logic ops keep sum.
                set_bit   = 1'b0;
            end
        endcase
    end

    assign result_next = is_set_op ? {{(WORDSIZE-1){1'b0}}, set_bit} : sum; // zero extended.

    // next state.
    // idle waits for req, ack waits for req to fall and release rests one cycle.
    always_comb begin
        state_next  = state;
        accept      = 1'b0;
        req_dropped = 1'b0;
        case (state)
            alu_pkg::st_idle: begin
                if (req) begin
                    state_next = alu_pkg::st_ack; // outputs load on this same edge.
                    accept     = 1'b1;
                end
            end
            alu_pkg::st_ack: begin
                if (!req) begin
                    state_next  = alu_pkg::st_release; // ack falls on this edge.
                    req_dropped = 1'b1;
                end
            end
            alu_pkg::st_release: state_next = alu_pkg::st_idle; // one cycle gap.
            default:             state_next = alu_pkg::st_idle; // unused encoding recovers.
        endcase
    end

    // handshake control.
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= alu_pkg::st_idle;
            ack   <= 1'b0;
        end else begin
            state <= state_next;
            if (accept) begin
                ack <= 1'b1;                    // high from the edge that took req.
            end else if (req_dropped) begin
                ack <= 1'b0;                    // low from the edge that saw req low.
            end
        end
    end

    // outputs hold from one accepted request to the next.
    always_ff @(posedge clk) begin
        if (rst) begin
            result         <= '0;
            overflow       <= 1'b0;
            flag_equal     <= 1'b0;
            flag_not_equal <= 1'b0;
            flag_greater   <= 1'b0;
            flag_less      <= 1'b0;
            flag_u_equal   <= 1'b0;
            flag_u_greater <= 1'b0;
            flag_u_less    <= 1'b0;
        end else if (accept) begin
            result         <= result_next;
            overflow       <= arith_overflow; // already zero for logic and set ops.
            flag_equal     <= flags.equal;
            flag_not_equal <= flags.not_equal;
            flag_greater   <= flags.greater;
            flag_less      <= flags.less;
            flag_u_equal   <= flags.u_equal;
            flag_u_greater <= flags.u_greater;
            flag_u_less    <= flags.u_less;
        end
    end

endmodule

//--- alu.sv
// -------------------------------------------------------------------------
// integer execute unit top level.
// joins the comparison unit, the arithmetic unit and the handshake
// collector behind plain ports.
// -------------------------------------------------------------------------
module alu #(
    parameter int WORDSIZE = alu_pkg::WORDSIZE_DEFAULT // operand width in bits.
) (
    input  logic                clk,            // rising edge clock.
    input  logic                rst,            // synchronous reset, active high.
    input  logic                req,            // four-phase request.
    input  alu_pkg::alu_op_t    op,             // operation to execute.
    input  logic [WORDSIZE-1:0] operand_a,      // first operand.
    input  logic [WORDSIZE-1:0] operand_b,      // second operand.
    output logic                ack,            // four-phase acknowledge.
    output logic [WORDSIZE-1:0] result,         // registered result.
    output logic                overflow,       // registered signed overflow.
    output logic                flag_equal,     // registered flags follow.
    output logic                flag_not_equal,
    output logic                flag_greater,
    output logic                flag_less,
    output logic                flag_u_equal,
    output logic                flag_u_greater,
    output logic                flag_u_less
);

    flag_bus             cmp_flags ();      // comparison flags toward the collector.
    logic [WORDSIZE-1:0] sum;               // raw arithmetic result.
    logic                arith_overflow;    // raw signed overflow.

    // both units read the operands straight from the top ports.
    compare_unit #(.WORDSIZE(WORDSIZE)) i_compare (
        .operand_a (operand_a),
        .operand_b (operand_b),
        .flags     (cmp_flags)
    );

    arith_unit #(.WORDSIZE(WORDSIZE)) i_arith (
        .op        (op),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .sum       (sum),
        .overflow  (arith_overflow)
    );

    exec_collect #(.WORDSIZE(WORDSIZE)) i_collect (
        .clk            (clk),
        .rst            (rst),
        .req            (req),
        .op             (op),
        .sum            (sum),
        .arith_overflow (arith_overflow),
        .flags          (cmp_flags),
        .ack            (ack),
        .result         (result),
        .overflow       (overflow),
        .flag_equal     (flag_equal),
        .flag_not_equal (flag_not_equal),
        .flag_greater   (flag_greater),
        .flag_less      (flag_less),
        .flag_u_equal   (flag_u_equal),
        .flag_u_greater (flag_u_greater),
        .flag_u_less    (flag_u_less)
    );

endmodule

//--- alu_properties.sv
// -------------------------------------------------------------------------
// handshake properties of the result collector.
// reset, ack rise after accept, result hold and ack fall after release.
// -------------------------------------------------------------------------
module alu_properties #(
    parameter int WORDSIZE = alu_pkg::WORDSIZE_DEFAULT // operand width in bits.
) (
    input logic                 clk,
    input logic                 rst,
    input logic                 req,
    input logic                 ack,
    input alu_pkg::exec_state_t state,
    input logic [WORDSIZE-1:0]  result
);
    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;                       // failed assertions so far.

    // a reset edge leaves ack low.
    ack_low_in_reset: assert property (@(posedge clk) rst |=> !ack)
        else begin
            failures++;
            $error("ack is high after a reset edge");
        end

    // req taken in idle raises ack on the very next cycle.
    ack_after_accept: assert property (@(posedge clk) disable iff (rst)
        (state == alu_pkg::st_idle && req) |=> ack)
        else begin
            failures++;
            $error("ack did not rise one cycle after req was accepted");
        end

    // ack never rises without an accepted request.
    ack_only_on_accept: assert property (@(posedge clk) disable iff (rst)
        (!ack ##1 ack) |-> $past(state == alu_pkg::st_idle && req))
        else begin
            failures++;
            $error("ack rose without an accepted request");
        end

    ack_result_hold: assert property (@(posedge clk) disable iff (rst)
        ack |=> (!ack || $stable(result)))
        else begin
            failures++;
            $error("result changed while ack was high");
        end

    ack_after_release: assert property (@(posedge clk) disable iff (rst)
        (state == alu_pkg::st_ack && !req) |=> !ack)
        else begin
            failures++;
            $error("ack did not fall one cycle after req dropped");
        end

endmodule

//--- tb_alu_checker.sv
// -------------------------------------------------------------------------
// execute unit checker.
// captures each request, predicts result, overflow and flags, compares
// them at the ack rise and while ack holds, and prints the test counts.
// -------------------------------------------------------------------------
module tb_alu_checker #(
    parameter int WORDSIZE = alu_pkg::WORDSIZE_DEFAULT // operand width in bits.
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                req,
    input  alu_pkg::alu_op_t    op,
    input  logic [WORDSIZE-1:0] operand_a,
    input  logic [WORDSIZE-1:0] operand_b,
    input  logic                ack,
    input  logic [WORDSIZE-1:0] result,
    input  logic                overflow,
    input  logic [6:0]          flags,          // equal down to u_less, msb first.
    input  logic [2:0]          test_id,
    input  logic                test_done,
    input  logic                run_done,
    output int                  error_count,
    output int                  check_count
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MSB = WORDSIZE - 1;

    alu_pkg::alu_op_t    held_op;               // request captured while req waits.
    logic [WORDSIZE-1:0] held_a;
    logic [WORDSIZE-1:0] held_b;
    logic [WORDSIZE-1:0] exp_result;
    logic                exp_overflow;
    logic [6:0]          exp_flags;
    logic                ack_prev;              // ack at the previous falling edge.
    int                  test_checks;
    int                  test_errors;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd0:    return "add_sub";
            3'd1:    return "logic_ops";
            3'd2:    return "compare_flags";
            3'd3:    return "set_ops";
            default: return "edge_values";
        endcase
    endfunction

    task automatic report_error(input string msg);
        error_count++;
        test_errors++;
        $display("Fail at %0d ns: %s", $time, msg);
    endtask

    // prediction straight from two's complement and unsigned order.
    task automatic compute_expected();
        logic [WORDSIZE:0] wide_sum;
        logic [WORDSIZE:0] wide_diff;
        logic              lt_s;
        logic              lt_u;
        logic              same;
        wide_sum     = {held_a[MSB], held_a} + {held_b[MSB], held_b}; // one extra sign bit.
        wide_diff    = {held_a[MSB], held_a} - {held_b[MSB], held_b};
        lt_s         = $signed(held_a) < $signed(held_b);
        lt_u         = held_a < held_b;
        same         = held_a == held_b;
        exp_result   = '0;
        exp_overflow = 1'b0;
        case (held_op)
            alu_pkg::op_add: begin
                exp_result   = wide_sum[MSB:0];
                exp_overflow = wide_sum[WORDSIZE] != wide_sum[MSB]; // true sign lost.
            end
            alu_pkg::op_sub: begin
                exp_result   = wide_diff[MSB:0];
                exp_overflow = wide_diff[WORDSIZE] != wide_diff[MSB];
            end
            alu_pkg::op_and:  exp_result = held_a & held_b;
            alu_pkg::op_or:   exp_result = held_a | held_b;
            alu_pkg::op_xor:  exp_result = held_a ^ held_b;
            alu_pkg::op_slt:  exp_result[0] = lt_s;
            alu_pkg::op_sltu: exp_result[0] = lt_u;
            default:          exp_result[0] = same; // equality set op.
        endcase
        exp_flags = {same, !same, !lt_s && !same, lt_s, same, !lt_u && !same, lt_u};
    endtask

    task automatic compare_outputs();
        check_count++;
        test_checks++;
        if (result !== exp_result) begin
            report_error($sformatf("%s a=%h b=%h result %h, expected %h", held_op.name(),
                                   held_a, held_b, result, exp_result));
        end
        if (overflow !== exp_overflow) begin
            report_error($sformatf("%s a=%h b=%h overflow %b, expected %b", held_op.name(),
                                   held_a, held_b, overflow, exp_overflow));
        end
        if (flags !== exp_flags) begin
            report_error($sformatf("a=%h b=%h flags %b, expected %b", held_a, held_b, flags,
                                   exp_flags));
        end
    endtask

    initial begin
        error_count = 0;
        check_count = 0;
        test_checks = 0;
        test_errors = 0;
        ack_prev    = 1'b0;
    end

    // falling edge sampling keeps clear of the rising edge updates.
    always @(negedge clk) begin
        if (rst) begin
            if (ack !== 1'b0 || result !== '0 || overflow !== 1'b0 || flags !== '0) begin
                report_error("ack or outputs not cleared by reset");
            end
        end else if (req && !ack) begin
            held_op = op;                       // inputs stay stable until ack is seen.
            held_a  = operand_a;
            held_b  = operand_b;
        end else if (ack && !ack_prev) begin
            compute_expected();
            compare_outputs();
        end else if (ack && (result !== exp_result || overflow !== exp_overflow
                             || flags !== exp_flags)) begin
            report_error("outputs changed while ack was high");
        end
        if (test_done) begin
            $display("test %s finished: %0d checks, %0d errors", test_name(test_id),
                     test_checks, test_errors);
            test_checks = 0;
            test_errors = 0;
        end
        if (run_done) begin
            $display("all tests finished: %0d checks, %0d errors", check_count, error_count);
        end
        ack_prev = ack;
    end

endmodule

//--- tb_alu.sv
// -------------------------------------------------------------------------
// testbench top for the integer execute unit.
// drives random requests over the four-phase handshake in five tests and
// leaves the comparing to the checker.
// -------------------------------------------------------------------------
module tb_alu;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WORDSIZE         = alu_pkg::WORDSIZE_DEFAULT;
    localparam int CLK_PERIOD       = 40;            // ns per clock cycle.
    localparam int STIM_DELAY       = 2;             // inputs change this long after the edge.
    localparam int NUM_TESTS        = 5;
    localparam int REQS_PER_TEST    = 200;
    localparam int TOTAL_REQS       = NUM_TESTS * REQS_PER_TEST;
    localparam int HANDSHAKE_CYCLES = 4;             // accept, drop, release and sampling slack.
    localparam int MAX_HOLD         = 3;             // extra cycles req stays high after ack.
    localparam int MAX_GAP          = 3;             // idle cycles between two requests.
    localparam int WATCHDOG_NS      = TOTAL_REQS * (HANDSHAKE_CYCLES + MAX_HOLD + MAX_GAP)
                                      * CLK_PERIOD + 50 * CLK_PERIOD;

    logic                clk;
    logic                rst;
    logic                req;
    alu_pkg::alu_op_t    op;
    logic [WORDSIZE-1:0] operand_a;
    logic [WORDSIZE-1:0] operand_b;
    logic                ack;
    logic [WORDSIZE-1:0] result;
    logic                overflow;
    wire  [6:0]          flags;                      // equal down to u_less, msb first.
    logic [2:0]          test_id;                    // test that is running now.
    logic                test_done;                  // one cycle pulse at the end of a test.
    logic                run_done;                   // one cycle pulse after the last test.
    logic [31:0]         lfsr_state;
    int                  error_count;
    int                  check_count;

    alu #(.WORDSIZE(WORDSIZE)) i_dut (
        .clk (clk), .rst (rst), .req (req), .op (op),
        .operand_a (operand_a), .operand_b (operand_b),
        .ack (ack), .result (result), .overflow (overflow),
        .flag_equal (flags[6]), .flag_not_equal (flags[5]), .flag_greater (flags[4]),
        .flag_less (flags[3]), .flag_u_equal (flags[2]), .flag_u_greater (flags[1]),
        .flag_u_less (flags[0])
    );

    tb_alu_checker #(.WORDSIZE(WORDSIZE)) i_checker (
        .clk (clk), .rst (rst), .req (req), .op (op),
        .operand_a (operand_a), .operand_b (operand_b),
        .ack (ack), .result (result), .overflow (overflow), .flags (flags),
        .test_id (test_id), .test_done (test_done), .run_done (run_done),
        .error_count (error_count), .check_count (check_count)
    );

    // handshake properties sit on the collector where the state is visible.
    bind exec_collect alu_properties #(.WORDSIZE(WORDSIZE)) i_properties (
        .clk (clk), .rst (rst), .req (req), .ack (ack), .state (state), .result (result)
    );

    // galois form of x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] cur);
        return cur[0] ? ((cur >> 1) ^ 32'h8020_0003) : (cur >> 1);
    endfunction

    // one lfsr step per bit, bits shift in from the right.
    task automatic take_bits(input int count, output logic [WORDSIZE-1:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[WORDSIZE-2:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [WORDSIZE-1:0] edge_value(input logic [2:0] sel,
                                                       input logic [WORDSIZE-1:0] rnd);
        case (sel)
            3'd0:    return '0;
            3'd1:    return {{(WORDSIZE-1){1'b0}}, 1'b1};
            3'd2:    return '1;                          // all ones, minus one when signed.
            3'd3:    return {1'b1, {(WORDSIZE-1){1'b0}}}; // most negative value.
            3'd4:    return {1'b0, {(WORDSIZE-1){1'b1}}}; // most positive value.
            default: return rnd;
        endcase
    endfunction

    task automatic choose_op(input int test, output alu_pkg::alu_op_t pick);
        logic [WORDSIZE-1:0] bits;
        take_bits(3, bits);
        case (test)
            0:       pick = bits[0] ? alu_pkg::op_sub : alu_pkg::op_add;
            1:       pick = alu_pkg::alu_op_t'(3'd2 + 3'(bits[1:0] % 2'd3)); // and, or, xor.
            3:       pick = alu_pkg::alu_op_t'(3'd5 + 3'(bits[1:0] % 2'd3)); // set ops.
            default: pick = alu_pkg::alu_op_t'(bits[2:0]); // every op mixed.
        endcase
    endtask

    task automatic choose_operands(input bit edges, output logic [WORDSIZE-1:0] a,
                                   output logic [WORDSIZE-1:0] b);
        logic [WORDSIZE-1:0] pick;
        take_bits(WORDSIZE, a);
        take_bits(WORDSIZE, b);
        if (edges) begin
            take_bits(3, pick);
            a = edge_value(pick[2:0], a);
            take_bits(3, pick);
            b = edge_value(pick[2:0], b);
        end
        take_bits(2, pick);
        if (pick[1:0] == 2'd0) begin
            b = a;                                   // a quarter of requests compare equal.
        end
    endtask

    // one full four-phase cycle with a random hold and idle gap.
    task automatic run_request(input alu_pkg::alu_op_t req_op, input logic [WORDSIZE-1:0] a,
                               input logic [WORDSIZE-1:0] b);
        logic [WORDSIZE-1:0] hold;
        logic [WORDSIZE-1:0] gap;
        take_bits(2, hold);
        take_bits(2, gap);
        op        = req_op;
        operand_a = a;
        operand_b = b;
        req       = 1'b1;
        do begin
            @(posedge clk);
            #STIM_DELAY;
        end while (!ack);
        repeat (hold) begin
            @(posedge clk);
            #STIM_DELAY;
        end
        req = 1'b0;
        do begin
            @(posedge clk);
            #STIM_DELAY;
        end while (ack);
        repeat (gap) begin
            @(posedge clk);
            #STIM_DELAY;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        alu_pkg::alu_op_t    next_op;
        logic [WORDSIZE-1:0] a;
        logic [WORDSIZE-1:0] b;
        rst        = 1'b1;
        req        = 1'b0;
        op         = alu_pkg::op_add;
        operand_a  = '0;
        operand_b  = '0;
        test_id    = 3'd0;
        test_done  = 1'b0;
        run_done   = 1'b0;
        lfsr_state = 32'd19;
        repeat (4) @(posedge clk);
        #STIM_DELAY;
        rst = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_id = 3'(t);
            for (int n = 0; n < REQS_PER_TEST; n++) begin
                choose_op(t, next_op);
                choose_operands(t == 4, a, b);        // the last test leans on edge values.
                run_request(next_op, a, b);
            end
            test_done = 1'b1;
            @(posedge clk);
            #STIM_DELAY;
            test_done = 1'b0;
        end
        run_done = 1'b1;
        @(posedge clk);
        #STIM_DELAY;
        run_done = 1'b0;
        @(posedge clk);
        #STIM_DELAY;
        if (error_count == 0 && check_count == TOTAL_REQS
            && i_dut.i_collect.i_properties.failures == 0) begin
            $display("Test OK");
        end else begin
            if (check_count != TOTAL_REQS) begin
                $display("checker counted %0d results for %0d requests", check_count,
                         TOTAL_REQS);
            end
            if (i_dut.i_collect.i_properties.failures != 0) begin
                $display("handshake assertions failed %0d times",
                         i_dut.i_collect.i_properties.failures);
            end
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the handshake stalled, the run did not end within %0d ns",
                 WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- compile.f
alu_pkg.sv
flag_bus.sv
compare_unit.sv
arith_unit.sv
exec_collect.sv
alu.sv
alu_properties.sv
tb_alu_checker.sv
tb_alu.sv
